//--- design/sprite_display_top.sv
`timescale 1ns/10ps
`default_nettype none

module sprite_display_top (
  input  logic              clk,
  input  logic              reset,
  input  video_pkg::coord_t sprite_x,   // held stable over a frame
  input  video_pkg::coord_t sprite_y,
  output video_pkg::rgb_t   rgb,
  output logic              hsync_out,
  output logic              vsync_out
);

  video_pkg::coord_t    hpos;
  video_pkg::coord_t    vpos;
  logic                 hsync;
  logic                 vsync;
  logic                 display_on;
  logic                 vstart;
  logic                 load;
  logic                 hstart;
  logic                 gfx;
  video_pkg::row_addr_t rom_addr;
  video_pkg::row_bits_t rom_bits;

  video_timing timing0 (
    .clk        (clk),
    .reset      (reset),
    .hpos       (hpos),
    .vpos       (vpos),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on)
  );

  sprite_overlay overlay0 (
    .clk        (clk),
    .reset      (reset),
    .hpos       (hpos),
    .vpos       (vpos),
    .sprite_x   (sprite_x),
    .sprite_y   (sprite_y),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .gfx        (gfx),
    .vstart     (vstart),
    .load       (load),
    .hstart     (hstart),
    .rgb        (rgb),
    .hsync_out  (hsync_out),
    .vsync_out  (vsync_out)
  );

  sprite_renderer renderer0 (
    .clk         (clk),
    .reset       (reset),
    .vstart      (vstart),
    .load        (load),
    .hstart      (hstart),
    .rom_addr    (rom_addr),
    .rom_bits    (rom_bits),
    .gfx         (gfx),
    .in_progress ()            // status only, nothing consumes it here
  );

  sprite_rom rom0 (
    .rom_addr (rom_addr),
    .rom_bits (rom_bits)
  );

endmodule

`default_nettype wire

//--- design/sprite_overlay.sv
`timescale 1ns/10ps
`default_nettype none

`include "video_defs.svh"

module sprite_overlay (
  input  logic              clk,
  input  logic              reset,
  input  video_pkg::coord_t hpos,
  input  video_pkg::coord_t vpos,
  input  video_pkg::coord_t sprite_x,    // sprite left column
  input  video_pkg::coord_t sprite_y,    // line before first sprite row
  input  logic              hsync,
  input  logic              vsync,
  input  logic              display_on,
  input  logic              gfx,         // renderer pixel, 2 cycles behind beam
  output logic              vstart,
  output logic              load,
  output logic              hstart,
  output video_pkg::rgb_t   rgb,         // 3 cycles behind beam
  output logic              hsync_out,
  output logic              vsync_out
);

  // stages before the output register
  localparam int DLY = `PIX_LATENCY - 1;

  logic [DLY-1:0] disp_dly;    // display_on delay line
  logic [DLY-1:0] hsync_dly;
  logic [DLY-1:0] vsync_dly;

  // renderer strobes, one cycle each
  assign vstart = (vpos == sprite_y) && (hpos == '0);
  assign load   = (hpos == video_pkg::coord_t'(`H_DISPLAY));  // start of hblank
  assign hstart = (hpos == sprite_x);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      disp_dly  <= '0;
      hsync_dly <= '0;
      vsync_dly <= '0;
      rgb       <= '0;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
    end else begin
      // msb lines up with gfx
      disp_dly  <= {disp_dly[DLY-2:0], display_on};
      hsync_dly <= {hsync_dly[DLY-2:0], hsync};
      vsync_dly <= {vsync_dly[DLY-2:0], vsync};
      // vsync edge lands 3 cycles into the line, like everything else
      hsync_out <= hsync_dly[DLY-1];
      vsync_out <= vsync_dly[DLY-1];
      if (!disp_dly[DLY-1])
        rgb <= '0;                    // blanking is black
      else if (gfx)
        rgb <= `SPRITE_COLOR;
      else
        rgb <= `BG_COLOR;
    end
  end

endmodule

`default_nettype wire

//--- design/sprite_renderer.sv
`timescale 1ns/10ps
`default_nettype none

`include "video_defs.svh"

// 16x16 sprite from 8-bit rows with the right half mirrored
module sprite_renderer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 vstart,      // beam on sprite top line
  input  logic                 load,        // hblank slot for row fetch
  input  logic                 hstart,      // beam on sprite left column
  output video_pkg::row_addr_t rom_addr,    // row being fetched
  input  video_pkg::row_bits_t rom_bits,    // comb. rom data
  output logic                 gfx,         // pixel, 2 + c cycles after hstart
  output logic                 in_progress  // low only while idle
);

  video_pkg::render_state_t state;
  video_pkg::row_addr_t     ycount;   // rows finished so far
  logic [3:0]               xcount;   // column within current row
  video_pkg::row_bits_t     outbits;  // latched row

  assign in_progress = (state != video_pkg::WAIT_VSTART);

  // row for the coming scanline
  always_ff @(posedge clk) begin
    if (state == video_pkg::LOAD_FETCH)
      outbits <= rom_bits;     // rom answers in same cycle
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= video_pkg::WAIT_VSTART;
      ycount   <= '0;
      xcount   <= '0;
      rom_addr <= '0;
      gfx      <= 1'b0;
    end else begin
      case (state)
        video_pkg::WAIT_VSTART: begin
          ycount <= '0;        // new frame, start at row 0
          gfx    <= 1'b0;
          if (vstart)
            state <= video_pkg::WAIT_LOAD;
        end
        video_pkg::WAIT_LOAD: begin
          xcount <= '0;
          gfx    <= 1'b0;      // blank between rows
          if (load)
            state <= video_pkg::LOAD_SETUP;
        end
        video_pkg::LOAD_SETUP: begin
          rom_addr <= ycount;  // present address
          state    <= video_pkg::LOAD_FETCH;
        end
        video_pkg::LOAD_FETCH: begin
          state <= video_pkg::WAIT_HSTART;  // outbits latched here
        end
        video_pkg::WAIT_HSTART: begin
          if (hstart)
            state <= video_pkg::DRAW;
        end
        video_pkg::DRAW: begin
          // cols 0..7 straight, cols 8..15 mirrored
          gfx    <= xcount[3] ? outbits[~xcount[2:0]] : outbits[xcount[2:0]];
          xcount <= xcount + 1'b1;
          if (xcount == 4'(`SPRITE_SIZE - 1)) begin   // last column
            ycount <= ycount + 1'b1;
            if (ycount == video_pkg::row_addr_t'(`SPRITE_SIZE - 1))
              state <= video_pkg::WAIT_VSTART;    // sprite done
            else
              state <= video_pkg::WAIT_LOAD;      // next row
          end
        end
        default: begin
          state <= video_pkg::WAIT_VSTART;        // recover
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/sprite_rom.sv
`timescale 1ns/10ps
`default_nettype none

module sprite_rom (
  input  video_pkg::row_addr_t rom_addr,  // sprite row
  output video_pkg::row_bits_t rom_bits   // same-cycle row data
);

  // one LUT per output bit after mapping
  always_comb begin
    case (rom_addr)
      4'd0:    rom_bits = video_pkg::sprite_bitmap[0];
      4'd1:    rom_bits = video_pkg::sprite_bitmap[1];
      4'd2:    rom_bits = video_pkg::sprite_bitmap[2];
      4'd3:    rom_bits = video_pkg::sprite_bitmap[3];
      4'd4:    rom_bits = video_pkg::sprite_bitmap[4];
      4'd5:    rom_bits = video_pkg::sprite_bitmap[5];
      4'd6:    rom_bits = video_pkg::sprite_bitmap[6];
      4'd7:    rom_bits = video_pkg::sprite_bitmap[7];
      4'd8:    rom_bits = video_pkg::sprite_bitmap[8];
      4'd9:    rom_bits = video_pkg::sprite_bitmap[9];
      4'd10:   rom_bits = video_pkg::sprite_bitmap[10];
      4'd11:   rom_bits = video_pkg::sprite_bitmap[11];
      4'd12:   rom_bits = video_pkg::sprite_bitmap[12];
      4'd13:   rom_bits = video_pkg::sprite_bitmap[13];
      4'd14:   rom_bits = video_pkg::sprite_bitmap[14];
      4'd15:   rom_bits = video_pkg::sprite_bitmap[15];
      default: rom_bits = '0;   // x address
    endcase
  end

endmodule

`default_nettype wire

//--- design/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// horizontal raster, in pixel clocks
`define H_DISPLAY     256   // visible width
`define H_TOTAL       309   // full line incl. blanking
`define H_SYNC_START  280   // first hsync cycle
`define H_SYNC_END    303   // last hsync cycle

// vertical raster, in lines
`define V_DISPLAY     240   // visible lines
`define V_TOTAL       262   // full frame incl. blanking
`define V_SYNC_START  244   // first vsync line
`define V_SYNC_END    247   // last vsync line

// sprite geometry
`define SPRITE_SIZE   16    // width and height, pixels / rows

// colours, 3-bit rgb
`define SPRITE_COLOR  3'b110  // lit sprite pixel
`define BG_COLOR      3'b001  // visible background

// counters -> rgb/sync output delay
`define PIX_LATENCY   3

`endif

//--- design/video_pkg.sv
`default_nettype none

`include "video_defs.svh"

package video_pkg;

  typedef logic [8:0] coord_t;                        // beam or sprite position
  typedef logic [7:0] row_bits_t;                     // bit n = column n
  typedef logic [$clog2(`SPRITE_SIZE)-1:0] row_addr_t; // sprite row index
  typedef logic [2:0] rgb_t;                          // r,g,b

  // renderer FSM
  typedef enum logic [2:0] {
    WAIT_VSTART,  // idle until sprite top line
    WAIT_LOAD,    // wait for hblank load slot
    LOAD_SETUP,   // present row address
    LOAD_FETCH,   // latch rom data
    WAIT_HSTART,  // wait for sprite left edge
    DRAW          // shifting out pixels
  } render_state_t;

  // left half of the image, mirrored for columns 8..15
  // bit 7 sits next to the centre line
  parameter row_bits_t sprite_bitmap [`SPRITE_SIZE] = '{
    8'b11000000,
    8'b11100000,
    8'b01110000,
    8'b00111000,
    8'b00011100,
    8'b10001110,
    8'b11000111,
    8'b11100011,
    8'b11110011,
    8'b11000111,
    8'b10001110,
    8'b00011100,
    8'b00111001,
    8'b01110011,
    8'b11100000,
    8'b11000000
  };

endpackage

`default_nettype wire

//--- design/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

`include "video_defs.svh"

module video_timing (
  input  logic                clk,
  input  logic                reset,
  output video_pkg::coord_t   hpos,        // current pixel in line
  output video_pkg::coord_t   vpos,        // current line in frame
  output logic                hsync,       // matches hpos/vpos of same cycle
  output logic                vsync,
  output logic                display_on   // beam inside visible area
);

  logic              h_last;   // last pixel of line
  logic              v_last;   // last line of frame
  video_pkg::coord_t h_next;
  video_pkg::coord_t v_next;

  assign h_last = (hpos == video_pkg::coord_t'(`H_TOTAL - 1));
  assign v_last = (vpos == video_pkg::coord_t'(`V_TOTAL - 1));

  // next counter values, flags are compared against these
  always_comb begin
    if (h_last) begin
      h_next = '0;               // wrap line
      if (v_last)
        v_next = '0;             // wrap frame
      else
        v_next = vpos + 1'b1;    // next line
    end else begin
      h_next = hpos + 1'b1;
      v_next = vpos;             // hold line
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hpos       <= '0;
      vpos       <= '0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      display_on <= 1'b1;        // (0,0) is a visible pixel
    end else begin
      hpos       <= h_next;
      vpos       <= v_next;
      hsync      <= (h_next >= video_pkg::coord_t'(`H_SYNC_START)) &&
                    (h_next <= video_pkg::coord_t'(`H_SYNC_END));
      vsync      <= (v_next >= video_pkg::coord_t'(`V_SYNC_START)) &&
                    (v_next <= video_pkg::coord_t'(`V_SYNC_END));
      display_on <= (h_next < video_pkg::coord_t'(`H_DISPLAY)) &&
                    (v_next < video_pkg::coord_t'(`V_DISPLAY));
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/video_pkg.sv
design/video_timing.sv
design/sprite_rom.sv
design/sprite_renderer.sv
design/sprite_overlay.sv
design/sprite_display_top.sv
tests/sprite_display_assertions.sv
tests/sprite_display_tb.sv

//--- tests/sprite_display_assertions.sv
`timescale 1ns/10ps
`default_nettype none

// renderer FSM properties bound into every sprite_renderer
module sprite_renderer_assertions (
  input logic                     clk,
  input logic                     reset,
  input logic                     vstart,
  input logic                     hstart,
  input logic                     gfx,
  input logic                     in_progress,
  input video_pkg::render_state_t state        // internal FSM state
);

  int fail_cnt = 0;   // failed assertions so far

  // gfx is registered, so a lit pixel needs a DRAW cycle just before it
  gfx_from_draw: assert property (
    @(posedge clk) disable iff (reset)
    gfx |-> ($past(state) == video_pkg::DRAW)
  ) else begin
    $error("gfx high without a DRAW cycle before it");
    fail_cnt++;
  end

  // two-cycle row fetch ends before the sprite's left edge comes round
  setup_then_fetch: assert property (
    @(posedge clk) disable iff (reset)
    (state == video_pkg::LOAD_SETUP) |->
      !hstart ##1 ((state == video_pkg::LOAD_FETCH) && !hstart)
  ) else begin
    $error("LOAD_SETUP not followed by LOAD_FETCH or hstart lost in the fetch");
    fail_cnt++;
  end

  // sprite top line arms the renderer
  busy_after_vstart: assert property (
    @(posedge clk) disable iff (reset)
    vstart |=> in_progress
  ) else begin
    $error("renderer idle in the cycle after vstart");
    fail_cnt++;
  end

endmodule

bind sprite_renderer sprite_renderer_assertions chk0 (
  .clk         (clk),
  .reset       (reset),
  .vstart      (vstart),
  .hstart      (hstart),
  .gfx         (gfx),
  .in_progress (in_progress),
  .state       (state)
);

`default_nettype wire

//--- tests/sprite_display_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "video_defs.svh"

module sprite_display_tb;

  localparam int WAIT_LIMIT = `H_TOTAL * `V_TOTAL + `H_TOTAL;  // a bit over one frame
  localparam int MOVE_LINE  = `V_DISPLAY + 10;                 // vblank while renderer idles

  logic              clk;
  logic              reset;
  video_pkg::coord_t sprite_x;
  video_pkg::coord_t sprite_y;
  video_pkg::rgb_t   rgb;
  logic              hsync_out;
  logic              vsync_out;

  int          tb_h;        // own copy of the dut beam counters
  int          tb_v;
  int          cycle_cnt;   // cycles since reset release
  logic [31:0] rnd_state;   // lcg state
  int          early_chk;   // reset and pipeline fill
  int          early_err;
  int          sync_chk;
  int          sync_err;
  int          vis_chk;     // rgb inside visible area
  int          vis_err;
  int          blank_chk;   // rgb in blanking
  int          blank_err;
  int          tests_run;
  int          tests_bad;
  bit          seq_ok;

  sprite_display_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .sprite_x  (sprite_x),
    .sprite_y  (sprite_y),
    .rgb       (rgb),
    .hsync_out (hsync_out),
    .vsync_out (vsync_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;    // 100 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected colour of beam position (x, y) with the sprite at (sx, sy)
  function automatic video_pkg::rgb_t expected_rgb(input int x, input int y,
                                                   input int sx, input int sy);
    int                   row;
    int                   col;
    video_pkg::row_bits_t bits;
    logic                 lit;
    if (x >= `H_DISPLAY || y >= `V_DISPLAY)
      return 3'b000;                      // blanking
    row = y - sy - 1;                     // row 0 one line below sprite_y
    col = x - sx;
    if (row < 0 || row >= `SPRITE_SIZE || col < 0 || col >= `SPRITE_SIZE)
      return `BG_COLOR;
    bits = video_pkg::sprite_bitmap[row];
    if (col < `SPRITE_SIZE / 2)
      lit = bits[col];
    else
      lit = bits[`SPRITE_SIZE - 1 - col]; // right half mirrored
    return lit ? `SPRITE_COLOR : `BG_COLOR;
  endfunction

  task automatic check_rgb(input video_pkg::rgb_t actual, input video_pkg::rgb_t expected,
                           output bit ok);
    ok = (actual === expected);
    if (!ok)
      $display("MISMATCH t=%0t signal=rgb expected=%b actual=%b", $time, expected, actual);
  endtask

  task automatic check_sync(input string name, input logic actual, input logic expected,
                            output bit ok);
    ok = (actual === expected);
    if (!ok)
      $display("MISMATCH t=%0t signal=%s expected=%b actual=%b", $time, name, expected, actual);
  endtask

  // outputs against the reference on every cycle after reset
  always @(negedge clk) begin : compare
    int              x;
    int              y;
    video_pkg::rgb_t exp_rgb;
    bit              ok_rgb;
    bit              ok_hs;
    bit              ok_vs;
    if (!reset) begin
      if (cycle_cnt < `PIX_LATENCY) begin
        check_rgb(rgb, 3'b000, ok_rgb);   // output regs still at reset value
        check_sync("hsync_out", hsync_out, 1'b0, ok_hs);
        check_sync("vsync_out", vsync_out, 1'b0, ok_vs);
        early_chk += 3;
        early_err += int'(!ok_rgb) + int'(!ok_hs) + int'(!ok_vs);
      end else begin
        x = tb_h - `PIX_LATENCY;          // outputs lag the beam
        y = tb_v;
        if (x < 0) begin
          x += `H_TOTAL;                  // tail of previous line
          y = (y == 0) ? `V_TOTAL - 1 : y - 1;
        end
        exp_rgb = expected_rgb(x, y, sprite_x, sprite_y);
        check_rgb(rgb, exp_rgb, ok_rgb);
        check_sync("hsync_out", hsync_out, (x >= `H_SYNC_START) && (x <= `H_SYNC_END), ok_hs);
        check_sync("vsync_out", vsync_out, (y >= `V_SYNC_START) && (y <= `V_SYNC_END), ok_vs);
        sync_chk += 2;
        sync_err += int'(!ok_hs) + int'(!ok_vs);
        if (x < `H_DISPLAY && y < `V_DISPLAY) begin
          vis_chk++;
          vis_err += int'(!ok_rgb);
        end else begin
          blank_chk++;
          blank_err += int'(!ok_rgb);
        end
      end
      cycle_cnt++;
      tb_h++;
      if (tb_h == `H_TOTAL) begin
        tb_h = 0;
        tb_v = (tb_v == `V_TOTAL - 1) ? 0 : tb_v + 1;
      end
    end
  end

  // returns at the edge that starts the cycle with counters (h, v)
  task automatic wait_for_position(input int h, input int v, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT) begin
      @(posedge clk);
      ok = (tb_h == h) && (tb_v == v);
      n++;
    end
    if (!ok)
      $display("timeout: beam never reached h=%0d v=%0d in %0d cycles", h, v, WAIT_LIMIT);
  endtask

  // new in-bounds position from the lcg
  task automatic move_sprite(output int nx, output int ny);
    rnd_state = lcg_next(rnd_state);
    nx = int'(rnd_state[23:8]) % (`H_DISPLAY - `SPRITE_SIZE);  // 0..239 so hblank load fits
    rnd_state = lcg_next(rnd_state);
    ny = int'(rnd_state[23:8]) % (`V_DISPLAY - `SPRITE_SIZE);  // last row still visible
    sprite_x <= video_pkg::coord_t'(nx);
    sprite_y <= video_pkg::coord_t'(ny);
  endtask

  task automatic report_test(input string name, input int checks, input int errs);
    tests_run++;
    if (errs != 0)
      tests_bad++;
    $display("test %-32s %7d checks %5d errors", name, checks, errs);
  endtask

  // frame 0 at (40,30) and then three random frames
  task automatic run_frames(output bit ok);
    int f;
    int fx;
    int fy;
    int nx;
    int ny;
    int s_sync_c;
    int s_sync_e;
    int s_blank_c;
    int s_blank_e;
    int s_vis_c;
    int s_vis_e;
    ok        = 1'b1;
    fx        = 40;
    fy        = 30;
    nx        = fx;
    ny        = fy;
    s_sync_c  = sync_chk;
    s_sync_e  = sync_err;
    s_blank_c = blank_chk;
    s_blank_e = blank_err;
    for (f = 0; f < 4; f++) begin
      s_vis_c = vis_chk;
      s_vis_e = vis_err;
      wait_for_position(0, MOVE_LINE, ok);
      if (!ok)
        return;
      if (f < 3)
        move_sprite(nx, ny);              // takes effect next frame
      wait_for_position(`PIX_LATENCY, 0, ok);   // last output of this frame done
      if (!ok)
        return;
      if (f == 0)
        report_test("sprite at (40,30)", vis_chk - s_vis_c, vis_err - s_vis_e);
      else
        report_test($sformatf("random frame %0d at (%0d,%0d)", f, fx, fy),
                    vis_chk - s_vis_c, vis_err - s_vis_e);
      fx = nx;
      fy = ny;
    end
    report_test("sync timing, frames 0-3", sync_chk - s_sync_c, sync_err - s_sync_e);
    report_test("blanking, frames 0-3", blank_chk - s_blank_c, blank_err - s_blank_e);
  endtask

  initial begin : main
    bit ok;
    int i;
    int total_chk;
    int total_err;
    int assert_err;
    reset     = 1'b1;
    sprite_x  = 9'd40;
    sprite_y  = 9'd30;
    rnd_state = 32'h941f;
    tb_h      = 0;
    tb_v      = 0;
    cycle_cnt = 0;
    early_chk = 0;
    early_err = 0;
    sync_chk  = 0;
    sync_err  = 0;
    vis_chk   = 0;
    vis_err   = 0;
    blank_chk = 0;
    blank_err = 0;
    tests_run = 0;
    tests_bad = 0;
    for (i = 0; i < 4; i++) begin
      @(negedge clk);                     // outputs held low in reset
      check_rgb(rgb, 3'b000, ok);
      early_err += int'(!ok);
      check_sync("hsync_out", hsync_out, 1'b0, ok);
      early_err += int'(!ok);
      check_sync("vsync_out", vsync_out, 1'b0, ok);
      early_err += int'(!ok);
      early_chk += 3;
    end
    @(posedge clk);
    reset <= 1'b0;
    wait_for_position(`PIX_LATENCY, 0, seq_ok);  // pipeline filled
    if (seq_ok) begin
      report_test("reset and pipeline fill", early_chk, early_err);
      run_frames(seq_ok);
    end
    assert_err = dut0.renderer0.chk0.fail_cnt;   // bound renderer checker
    total_chk  = early_chk + sync_chk + vis_chk + blank_chk;
    total_err  = early_err + sync_err + vis_err + blank_err;
    $display("%0d tests, %0d with errors, %0d checks, %0d mismatches, %0d assertion failures",
             tests_run, tests_bad, total_chk, total_err, assert_err);
    if (seq_ok && tests_bad == 0 && total_err == 0 && assert_err == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
